// ==== Makefile ====
SIM = obj_dir/sim_cpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f sources.f --top-module tb_cpu -o sim_cpu

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== addr_sequencer.sv ====
`timescale 1ns/1ps

module addr_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ce,
    input  cpu_pkg::byte_t      i_data,
    output cpu_pkg::addr_t      address,
    output cpu_pkg::byte_t      o_data,
    output logic                mreq,
    output logic                sync,
    output cpu_pkg::byte_t      opcode,
    input  cpu_pkg::addr_mode_e mode,
    input  cpu_pkg::alu_op_e    op,
    input  cpu_pkg::dest_e      dest,
    input  logic                is_store,
    input  logic                is_cmp,
    input  cpu_pkg::byte_t      reg_a,
    input  cpu_pkg::byte_t      reg_x,
    input  cpu_pkg::byte_t      reg_y,
    input  cpu_pkg::byte_t      flags,
    output cpu_pkg::byte_t      alu_a,
    output cpu_pkg::byte_t      alu_b,
    output cpu_pkg::alu_op_e    alu_op,
    output logic                alu_cin,
    input  cpu_pkg::byte_t      alu_res,
    input  logic                alu_cout,
    output logic                wr_en,
    output cpu_pkg::dest_e      wr_dest,
    output logic                wr_flags
);

    cpu_pkg::mcycle_e state;
    cpu_pkg::mcycle_e mem_state;   // Final cycle for read or write
    cpu_pkg::addr_t   pc;
    cpu_pkg::addr_t   ea;          // Effective address
    cpu_pkg::byte_t   tmp;         // Pointer low byte
    cpu_pkg::byte_t   opcode_q;
    cpu_pkg::byte_t   idx;
    logic             page_c;      // Carry out of the low byte add
    logic             use_ea;
    logic             lo_index;    // zpx and ndx add X to the low byte

    // ------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------
    assign opcode    = (state == cpu_pkg::FETCH) ? i_data : opcode_q;  // Decode live in FETCH
    assign sync      = (state == cpu_pkg::FETCH);
    assign mreq      = (state == cpu_pkg::STORE) && ce;                // Frozen core never writes
    assign o_data    = (state == cpu_pkg::STORE) ? reg_a : 8'h00;
    assign mem_state = is_store ? cpu_pkg::STORE : cpu_pkg::EXEC;
    assign idx       = (mode == cpu_pkg::ABY || mode == cpu_pkg::NDY) ? reg_y : reg_x;
    assign lo_index  = (mode == cpu_pkg::ZPX || mode == cpu_pkg::NDX);

    always_comb begin
        case (state)
            cpu_pkg::PTRL, cpu_pkg::PTRH, cpu_pkg::INDEX, cpu_pkg::STORE: use_ea = 1'b1;
            cpu_pkg::EXEC: use_ea = (mode != cpu_pkg::IMM) && (mode != cpu_pkg::IMP);
            default: use_ea = 1'b0;
        endcase
    end

    assign address = use_ea ? ea : pc;

    // ------------------------------------------------------------
    // ALU operands and write-back strobes per micro-cycle
    // ------------------------------------------------------------
    always_comb begin
        alu_a    = i_data;        // Low byte plus index by default
        alu_b    = idx;
        alu_op   = cpu_pkg::ADD;
        alu_cin  = 1'b0;
        wr_en    = 1'b0;
        wr_dest  = dest;
        wr_flags = (dest != cpu_pkg::NONE) || is_cmp;

        case (state)
            cpu_pkg::INDEX: begin
                if (lo_index) begin
                    alu_a = ea[7:0];      // Wraps inside zero page
                end else begin
                    alu_a   = ea[15:8];   // High byte fix-up
                    alu_b   = 8'h00;
                    alu_cin = page_c;
                end
            end
            cpu_pkg::EXEC: begin
                alu_a   = reg_a;
                alu_b   = i_data;         // Memory or immediate byte
                alu_op  = op;
                alu_cin = flags[cpu_pkg::FLAG_C];
                wr_en   = (mode != cpu_pkg::IMP);
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------
    // Micro-cycle FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= cpu_pkg::FETCH;
            pc       <= cpu_pkg::RESET_PC;
            ea       <= '0;
            tmp      <= '0;
            opcode_q <= '0;
            page_c   <= 1'b0;
        end else if (ce) begin
            case (state)
                cpu_pkg::FETCH: begin
                    opcode_q <= i_data;
                    pc       <= pc + 16'd1;
                    state    <= (mode == cpu_pkg::IMM || mode == cpu_pkg::IMP) ?
                                cpu_pkg::EXEC : cpu_pkg::OPER;
                end
                cpu_pkg::OPER: begin
                    pc <= pc + 16'd1;
                    case (mode)
                        cpu_pkg::ABX, cpu_pkg::ABY: begin
                            ea[7:0] <= alu_res;
                            page_c  <= alu_cout;
                            state   <= cpu_pkg::ADDH;
                        end
                        cpu_pkg::ABS: begin
                            ea[7:0] <= i_data;
                            state   <= cpu_pkg::ADDH;
                        end
                        default: begin    // Zero page based modes
                            ea    <= {8'h00, i_data};
                            state <= (mode == cpu_pkg::ZP)  ? mem_state :
                                     (mode == cpu_pkg::NDY) ? cpu_pkg::PTRL : cpu_pkg::INDEX;
                        end
                    endcase
                end
                cpu_pkg::ADDH: begin
                    pc       <= pc + 16'd1;
                    ea[15:8] <= i_data;
                    // Indexed STA always pays the fix-up cycle
                    if (mode != cpu_pkg::ABS && (page_c || is_store))
                        state <= cpu_pkg::INDEX;
                    else
                        state <= mem_state;
                end
                cpu_pkg::INDEX: begin
                    if (lo_index) begin
                        ea[7:0] <= alu_res;
                        state   <= (mode == cpu_pkg::NDX) ? cpu_pkg::PTRL : mem_state;
                    end else begin
                        ea[15:8] <= alu_res;
                        state    <= mem_state;
                    end
                end
                cpu_pkg::PTRL: begin
                    ea[7:0] <= ea[7:0] + 8'd1;    // Pointer high also wraps in page 0
                    if (mode == cpu_pkg::NDY) begin
                        tmp    <= alu_res;        // Low byte plus Y
                        page_c <= alu_cout;
                    end else begin
                        tmp <= i_data;
                    end
                    state <= cpu_pkg::PTRH;
                end
                cpu_pkg::PTRH: begin
                    ea <= {i_data, tmp};
                    if (mode == cpu_pkg::NDY && (page_c || is_store))
                        state <= cpu_pkg::INDEX;
                    else
                        state <= mem_state;
                end
                cpu_pkg::EXEC: begin
                    if (mode == cpu_pkg::IMM)
                        pc <= pc + 16'd1;         // Step past the immediate byte
                    state <= cpu_pkg::FETCH;
                end
                default: state <= cpu_pkg::FETCH;  // STORE
            endcase
        end
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::byte_t   a,
    input  cpu_pkg::byte_t   b,
    input  cpu_pkg::alu_op_e op,
    input  logic             carry_in,
    input  cpu_pkg::byte_t   flags_in,
    output cpu_pkg::byte_t   result,
    output cpu_pkg::byte_t   flags_out,
    output logic             carry_out
);

    logic           subtract;     // SBC and CMP invert B
    cpu_pkg::byte_t b_eff;
    logic           cin_eff;
    logic [8:0]     sum;          // Shared 9-bit adder
    cpu_pkg::byte_t nz_val;       // Value behind N and Z

    assign subtract  = (op == cpu_pkg::SBC) || (op == cpu_pkg::CMP);
    assign b_eff     = subtract ? ~b : b;
    assign cin_eff   = (op == cpu_pkg::CMP) ? 1'b1 : carry_in;  // Compare has no borrow-in
    assign sum       = {1'b0, a} + {1'b0, b_eff} + {8'h00, cin_eff};
    assign carry_out = sum[8];

    always_comb begin
        result    = a;
        flags_out = flags_in;
        nz_val    = sum[7:0];

        case (op)
            cpu_pkg::ORA: result = a | b;
            cpu_pkg::AND: result = a & b;
            cpu_pkg::EOR: result = a ^ b;
            cpu_pkg::LDA: result = b;
            cpu_pkg::ADC, cpu_pkg::SBC: begin
                result                     = sum[7:0];
                flags_out[cpu_pkg::FLAG_C] = sum[8];
                // Overflow when both inputs agree in sign and result does not
                flags_out[cpu_pkg::FLAG_V] = (a[7] == b_eff[7]) && (sum[7] != a[7]);
            end
            cpu_pkg::CMP: flags_out[cpu_pkg::FLAG_C] = sum[8];   // A kept, nz from difference
            default: result = sum[7:0];                         // ADD
        endcase

        if (op != cpu_pkg::CMP)
            nz_val = result;

        // Address add never touches P
        if (op != cpu_pkg::ADD) begin
            flags_out[cpu_pkg::FLAG_N] = nz_val[7];
            flags_out[cpu_pkg::FLAG_Z] = (nz_val == 8'h00);
        end
    end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

    // ------------------------------------------------------------
    // Basic widths
    // ------------------------------------------------------------
    typedef logic [7:0]  byte_t;   // Data byte
    typedef logic [15:0] addr_t;   // Bus address

    // Addressing modes of the group one layout
    typedef enum logic [3:0] {
        IMP,                       // Implied, runs as a NOP
        IMM,                       // #imm
        ZP,                        // zp
        ZPX,                       // zp,X with zero page wrap
        ABS,                       // abs
        ABX,                       // abs,X
        ABY,                       // abs,Y
        NDX,                       // (zp,X)
        NDY                        // (zp),Y
    } addr_mode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ORA,
        AND,
        EOR,
        ADC,
        LDA,                       // Pass B through
        CMP,                       // Flags only
        SBC,
        ADD                        // Address adder, flags untouched
    } alu_op_e;

    // Register written back by EXEC
    typedef enum logic [1:0] {
        NONE,
        A,
        X,
        Y
    } dest_e;

    // Micro-cycles of the sequencer
    typedef enum logic [2:0] {
        FETCH,                     // Opcode fetch, sync high
        OPER,                      // First operand byte
        PTRL,                      // Pointer low read
        PTRH,                      // Pointer high read
        ADDH,                      // Absolute high byte
        INDEX,                     // Index add or page fix-up
        EXEC,                      // ALU on memory byte
        STORE                      // Write A
    } mcycle_e;

    localparam addr_t RESET_PC = 16'h8000;

    // Special opcodes outside the plain group one decode
    localparam byte_t OPC_LDX_IMM = 8'hA2;
    localparam byte_t OPC_LDY_IMM = 8'hA0;
    localparam byte_t OPC_STA_IMM = 8'h89;  // No such instruction

    // Bit positions in P
    localparam int unsigned FLAG_C = 0;
    localparam int unsigned FLAG_Z = 1;
    localparam int unsigned FLAG_V = 6;
    localparam int unsigned FLAG_N = 7;

endpackage

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ce,         // Low freezes the core
    output cpu_pkg::addr_t address,
    input  cpu_pkg::byte_t i_data,     // Same-cycle read data
    output cpu_pkg::byte_t o_data,
    output logic           mreq,       // Store strobe
    output logic           sync        // Opcode fetch
);

    // ------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------
    cpu_pkg::byte_t      opcode;
    cpu_pkg::addr_mode_e mode;
    cpu_pkg::alu_op_e    op;
    cpu_pkg::dest_e      dest;
    logic                is_store;
    logic                is_cmp;
    cpu_pkg::byte_t      reg_a;
    cpu_pkg::byte_t      reg_x;
    cpu_pkg::byte_t      reg_y;
    cpu_pkg::byte_t      flags;
    cpu_pkg::byte_t      alu_a;
    cpu_pkg::byte_t      alu_b;
    cpu_pkg::alu_op_e    alu_op;
    logic                alu_cin;
    cpu_pkg::byte_t      alu_res;
    cpu_pkg::byte_t      alu_flags;
    logic                alu_cout;
    logic                wr_en;
    cpu_pkg::dest_e      wr_dest;
    logic                wr_flags;

    addr_sequencer addr_sequencer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ce       (ce),
        .i_data   (i_data),
        .address  (address),
        .o_data   (o_data),
        .mreq     (mreq),
        .sync     (sync),
        .opcode   (opcode),
        .mode     (mode),
        .op       (op),
        .dest     (dest),
        .is_store (is_store),
        .is_cmp   (is_cmp),
        .reg_a    (reg_a),
        .reg_x    (reg_x),
        .reg_y    (reg_y),
        .flags    (flags),
        .alu_a    (alu_a),
        .alu_b    (alu_b),
        .alu_op   (alu_op),
        .alu_cin  (alu_cin),
        .alu_res  (alu_res),
        .alu_cout (alu_cout),
        .wr_en    (wr_en),
        .wr_dest  (wr_dest),
        .wr_flags (wr_flags)
    );

    opcode_decode opcode_decode_i (
        .opcode   (opcode),
        .mode     (mode),
        .op       (op),
        .dest     (dest),
        .is_store (is_store),
        .is_cmp   (is_cmp)
    );

    alu alu_i (
        .a         (alu_a),
        .b         (alu_b),
        .op        (alu_op),
        .carry_in  (alu_cin),
        .flags_in  (flags),
        .result    (alu_res),
        .flags_out (alu_flags),
        .carry_out (alu_cout)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ce        (ce),
        .wr_en     (wr_en),
        .wr_dest   (wr_dest),
        .wr_flags  (wr_flags),
        .result    (alu_res),
        .flags_new (alu_flags),
        .reg_a     (reg_a),
        .reg_x     (reg_x),
        .reg_y     (reg_y),
        .flags     (flags)
    );

endmodule

// ==== opcode_decode.sv ====
`timescale 1ns/1ps

module opcode_decode (
    input  cpu_pkg::byte_t     opcode,
    output cpu_pkg::addr_mode_e mode,
    output cpu_pkg::alu_op_e   op,
    output cpu_pkg::dest_e     dest,
    output logic               is_store,
    output logic               is_cmp
);

    always_comb begin
        // Unknown opcodes end up as a two cycle NOP
        mode     = cpu_pkg::IMP;
        op       = cpu_pkg::LDA;
        dest     = cpu_pkg::NONE;
        is_store = 1'b0;
        is_cmp   = 1'b0;

        if (opcode == cpu_pkg::OPC_LDX_IMM) begin
            mode = cpu_pkg::IMM;               // LDX #imm
            dest = cpu_pkg::X;
        end else if (opcode == cpu_pkg::OPC_LDY_IMM) begin
            mode = cpu_pkg::IMM;               // LDY #imm
            dest = cpu_pkg::Y;
        end else if (opcode[1:0] == 2'b01 && opcode != cpu_pkg::OPC_STA_IMM) begin
            // Middle bits bbb pick the mode
            case (opcode[4:2])
                3'b000: mode = cpu_pkg::NDX;
                3'b001: mode = cpu_pkg::ZP;
                3'b010: mode = cpu_pkg::IMM;
                3'b011: mode = cpu_pkg::ABS;
                3'b100: mode = cpu_pkg::NDY;
                3'b101: mode = cpu_pkg::ZPX;
                3'b110: mode = cpu_pkg::ABY;
                default: mode = cpu_pkg::ABX;
            endcase

            // Top bits aaa pick the operation
            dest = cpu_pkg::A;
            case (opcode[7:5])
                3'b000: op = cpu_pkg::ORA;
                3'b001: op = cpu_pkg::AND;
                3'b010: op = cpu_pkg::EOR;
                3'b011: op = cpu_pkg::ADC;
                3'b100: begin                  // STA
                    dest     = cpu_pkg::NONE;
                    is_store = 1'b1;
                end
                3'b101: op = cpu_pkg::LDA;
                3'b110: begin                  // CMP leaves A alone
                    op     = cpu_pkg::CMP;
                    dest   = cpu_pkg::NONE;
                    is_cmp = 1'b1;
                end
                default: op = cpu_pkg::SBC;
            endcase
        end
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ce,
    input  logic           wr_en,
    input  cpu_pkg::dest_e wr_dest,
    input  logic           wr_flags,
    input  cpu_pkg::byte_t result,
    input  cpu_pkg::byte_t flags_new,
    output cpu_pkg::byte_t reg_a,
    output cpu_pkg::byte_t reg_x,
    output cpu_pkg::byte_t reg_y,
    output cpu_pkg::byte_t flags
);

    // Architectural state, all zero out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_a <= '0;
            reg_x <= '0;
            reg_y <= '0;
            flags <= '0;
        end else if (ce && wr_en) begin
            case (wr_dest)
                cpu_pkg::A: reg_a <= result;
                cpu_pkg::X: reg_x <= result;
                cpu_pkg::Y: reg_y <= result;
                default: ;                     // CMP writes P only
            endcase
            if (wr_flags)
                flags <= flags_new;
        end
    end

endmodule

// ==== sources.f ====
cpu_pkg.sv
opcode_decode.sv
alu.sv
addr_sequencer.sv
reg_file.sv
cpu_top.sv
tb_cpu.sv

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

    localparam int N_INSTR         = 200;
    localparam int CLK_PERIOD      = 20;
    localparam int WATCHDOG_CYCLES = N_INSTR * 8 * 2 + 200;  // Worst case plus ce gaps
    localparam cpu_pkg::addr_t DATA_LO = 16'h2000;          // Two data pages
    localparam cpu_pkg::addr_t DATA_HI = 16'h2200;

    logic           clk;
    logic           rst_n;
    logic           ce;
    cpu_pkg::addr_t address;
    cpu_pkg::byte_t i_data;
    cpu_pkg::byte_t o_data;
    logic           mreq;
    logic           sync;

    cpu_pkg::byte_t mem       [0:65535];   // DUT side memory
    cpu_pkg::byte_t model_mem [0:65535];   // Reference copy
    logic [31:0]    lfsr;

    // Reference model state
    cpu_pkg::byte_t m_a, m_x, m_y;
    logic           m_c, m_z, m_v, m_n;
    cpu_pkg::addr_t m_pc;
    cpu_pkg::addr_t st_addr_q [$];         // Pending STA writes
    cpu_pkg::byte_t st_data_q [$];
    int             instr_done;
    logic           first_sync;
    logic           prev_frozen;
    cpu_pkg::addr_t prev_addr;
    logic           prev_sync;

    cpu_top cpu_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ce      (ce),
        .address (address),
        .i_data  (i_data),
        .o_data  (o_data),
        .mreq    (mreq),
        .sync    (sync)
    );

    assign i_data = mem[address];          // Same cycle read

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    // 32-bit Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic cpu_pkg::byte_t rand_bits(input int n);
        cpu_pkg::byte_t v;
        logic           fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[6:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("ERROR: %s", why);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic put_byte(input cpu_pkg::addr_t a, input cpu_pkg::byte_t d);
        mem[a]       = d;
        model_mem[a] = d;
    endtask

    task automatic set_nz(input cpu_pkg::byte_t v);
        m_n = v[7];
        m_z = (v == 8'h00);
    endtask

    // Binary add with carry where SBC passes the inverted operand
    task automatic add_with_carry(input cpu_pkg::byte_t b);
        logic [8:0] sum;
        sum = {1'b0, m_a} + {1'b0, b} + {8'h00, m_c};
        m_v = (m_a[7] == b[7]) && (sum[7] != m_a[7]);
        m_c = sum[8];
        m_a = sum[7:0];
        set_nz(m_a);
    endtask

    // ------------------------------------------------------------
    // Memory image and random program
    // ------------------------------------------------------------
    task automatic build_program;
        cpu_pkg::addr_t pc;
        cpu_pkg::addr_t t;
        cpu_pkg::byte_t r, aaa, bbb, gx, k, lo;
        logic           hi_bit;
        for (int i = 0; i < 65536; i++) begin
            mem[i[15:0]]       = i[7:0] ^ i[15:8] ^ 8'h5A;   // Fill pattern
            model_mem[i[15:0]] = i[7:0] ^ i[15:8] ^ 8'h5A;
        end
        for (int i = 0; i < 'hF0; i++)
            put_byte(i[15:0], rand_bits(8));             // Zero page data
        for (cpu_pkg::addr_t a = DATA_LO; a < DATA_HI; a++)
            put_byte(a, rand_bits(8));
        for (int i = 0; i < 8; i++) begin
            put_byte(16'h00F0 + 16'(2 * i), rand_bits(8));   // Pointer pairs at F0..FF
            put_byte(16'h00F1 + 16'(2 * i), 8'h20);
        end

        pc = cpu_pkg::RESET_PC;
        gx = 8'h00;                                      // X as the program sees it
        for (int n = 0; n < N_INSTR; n++) begin
            r = rand_bits(4);
            if (r < 8'd2) begin                          // LDX or LDY immediate
                put_byte(pc, (r == 8'd0) ? 8'hA2 : 8'hA0);
                lo = rand_bits(8);
                put_byte(pc + 16'd1, lo);
                if (r == 8'd0)
                    gx = lo;
                pc = pc + 16'd2;
            end else begin
                aaa = (r < 8'd5) ? 8'd4 : rand_bits(3);  // STA weighted up
                bbb = rand_bits(3);
                if (aaa == 8'd4 && (bbb == 8'd1 || bbb == 8'd2 || bbb == 8'd5))
                    bbb = 8'd3;                          // Stores only into data pages
                put_byte(pc, {aaa[2:0], bbb[2:0], 2'b01});
                k = rand_bits(3);
                case (bbb)
                    8'd0: put_byte(pc + 16'd1, 8'hF0 + {k[6:0], 1'b0} - gx);  // Lands on a pointer
                    8'd4: put_byte(pc + 16'd1, 8'hF0 + {k[6:0], 1'b0});
                    8'd3: begin
                        hi_bit = rand_bits(1) != 8'd0;
                        t      = DATA_LO + {7'h00, hi_bit, rand_bits(8)};
                        put_byte(pc + 16'd2, t[15:8]);
                        put_byte(pc + 16'd1, t[7:0]);
                    end
                    8'd6, 8'd7: begin                    // Base in page 20 that may cross
                        put_byte(pc + 16'd1, rand_bits(8));
                        put_byte(pc + 16'd2, 8'h20);
                    end
                    default: put_byte(pc + 16'd1, rand_bits(8));  // zp, zpx, imm
                endcase
                pc = pc + ((bbb == 8'd3 || bbb >= 8'd6) ? 16'd3 : 16'd2);
            end
        end
        for (int i = 0; i < 8; i++)
            put_byte(pc + 16'(i), 8'hEA);                // Runs on as NOPs
    endtask

    // ------------------------------------------------------------
    // Instruction level reference model
    // ------------------------------------------------------------
    task automatic model_step;
        cpu_pkg::byte_t opc, b1, b2, m, ptr;
        cpu_pkg::addr_t ea;
        logic [8:0]     diff;
        logic           imm;
        opc = model_mem[m_pc];
        b1  = model_mem[m_pc + 16'd1];
        b2  = model_mem[m_pc + 16'd2];
        imm = 1'b0;
        ea  = '0;
        if (opc == 8'hA2 || opc == 8'hA0) begin
            if (opc == 8'hA2)
                m_x = b1;
            else
                m_y = b1;
            set_nz(b1);
            m_pc = m_pc + 16'd2;
        end else begin
            case (opc[4:2])
                3'd0: begin                              // (zp,X) where both bytes wrap
                    ptr = b1 + m_x;
                    ea  = {model_mem[{8'h00, ptr + 8'd1}], model_mem[{8'h00, ptr}]};
                end
                3'd1: ea = {8'h00, b1};
                3'd2: imm = 1'b1;
                3'd3: ea = {b2, b1};
                3'd4: ea = {model_mem[{8'h00, b1 + 8'd1}], model_mem[{8'h00, b1}]}
                           + {8'h00, m_y};
                3'd5: ea = {8'h00, b1 + m_x};             // Stays in page 0
                3'd6: ea = {b2, b1} + {8'h00, m_y};
                default: ea = {b2, b1} + {8'h00, m_x};
            endcase
            m_pc = m_pc + ((opc[4:2] == 3'd3 || opc[4:2] >= 3'd6) ? 16'd3 : 16'd2);
            m    = imm ? b1 : model_mem[ea];
            case (opc[7:5])
                3'd0: begin
                    m_a = m_a | m;
                    set_nz(m_a);
                end
                3'd1: begin
                    m_a = m_a & m;
                    set_nz(m_a);
                end
                3'd2: begin
                    m_a = m_a ^ m;
                    set_nz(m_a);
                end
                3'd3: add_with_carry(m);
                3'd4: begin
                    st_addr_q.push_back(ea);
                    st_data_q.push_back(m_a);
                    model_mem[ea] = m_a;
                end
                3'd5: begin
                    m_a = m;
                    set_nz(m_a);
                end
                3'd6: begin                              // CMP sets flags only
                    diff = {1'b0, m_a} + {1'b0, ~m} + 9'd1;
                    m_c  = diff[8];
                    set_nz(diff[7:0]);
                end
                default: add_with_carry(~m);
            endcase
        end
    endtask

    // ------------------------------------------------------------
    // Bus monitor sampled at the rising edge
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (prev_frozen) begin                       // Outputs held through ce low
                check_value("hold address", int'(prev_addr), int'(address));
                check_value("hold sync", int'(prev_sync), int'(sync));
            end
            if (!ce && mreq)
                stop_run("mreq went high while ce was low");
            prev_frozen = !ce;
            prev_addr   = address;
            prev_sync   = sync;

            if (ce && mreq) begin
                if (st_addr_q.size() == 0)
                    stop_run("mreq seen with no STA pending");
                check_value("store address", int'(st_addr_q.pop_front()), int'(address));
                check_value("store data", int'(st_data_q.pop_front()), int'(o_data));
                mem[address] <= o_data;
            end

            if (ce && first_sync) begin
                check_value("reset fetch sync", 1, int'(sync));
                check_value("reset vector", int'(cpu_pkg::RESET_PC), int'(address));
                first_sync = 1'b0;
            end

            if (ce && sync) begin
                if (st_addr_q.size() != 0)
                    stop_run("an STA finished without its store");
                check_value("fetch pc", int'(m_pc), int'(address));
                if (instr_done == N_INSTR) begin
                    for (cpu_pkg::addr_t a = DATA_LO; a < DATA_HI; a++)
                        check_value("data page byte", int'(model_mem[a]), int'(mem[a]));
                    $display(">>> PASS");
                    $finish;
                end else begin
                    model_step();
                    instr_done = instr_done + 1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        rst_n       = 1'b0;
        ce          = 1'b1;
        lfsr        = 32'd71411;
        m_a         = 8'h00;
        m_x         = 8'h00;
        m_y         = 8'h00;
        {m_c, m_z, m_v, m_n} = 4'b0000;
        m_pc        = cpu_pkg::RESET_PC;
        instr_done  = 0;
        first_sync  = 1'b1;
        prev_frozen = 1'b0;
        prev_addr   = '0;
        prev_sync   = 1'b0;
        build_program();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        forever begin
            @(negedge clk);
            ce = (rand_bits(3) != 8'd0);                 // Low about one cycle in eight
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: program did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
